// File: logic/aes_pkg.sv
// aes-128 engine shared package: widths, address map and round core states
`default_nettype none

package aes_pkg;

    // one state or key byte
    typedef logic [7:0] byte_t;
    // host write word, also one key schedule word
    typedef logic [31:0] word_t;
    // full state, byte 0 in the msb, column-major
    typedef logic [127:0] block_t;
    // host write address
    typedef logic [3:0] addr_t;
    // round counter and subbytes byte index
    typedef logic [3:0] round_t;
    typedef logic [3:0] byte_idx_t;

    // address map, key words 0..3 then data words 4..7, word 0 is the msw
    localparam addr_t ADDR_KEY0  = 4'd0;
    localparam addr_t ADDR_DATA0 = 4'd4;
    // control word, bit 0 requests start
    localparam addr_t ADDR_CTRL  = 4'd8;

    // aes-128 round count
    localparam int AES_ROUNDS = 10;

    typedef enum logic [2:0] {IDLE, INIT_ADD, SUB_BYTES, MIX_ADD, HOLD} core_state_t;

endpackage

`default_nettype wire

// File: logic/aes_sbox.sv
// aes s-box, gf(2^8) inverse by a fixed power chain then the affine transform
`default_nettype none
`timescale 1ns/1ps

module aes_sbox (
    input  aes_pkg::byte_t in_byte,
    output aes_pkg::byte_t out_byte
);

    // shift-and-add multiply mod x^8 + x^4 + x^3 + x + 1
    function automatic aes_pkg::byte_t gf_mul(input aes_pkg::byte_t a, input aes_pkg::byte_t b);
        aes_pkg::byte_t acc;
        aes_pkg::byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            // xtime on the running multiplicand
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // squares x^2 .. x^128
    aes_pkg::byte_t p2;
    aes_pkg::byte_t p4;
    aes_pkg::byte_t p8;
    aes_pkg::byte_t p16;
    aes_pkg::byte_t p32;
    aes_pkg::byte_t p64;
    aes_pkg::byte_t p128;
    // running products towards x^254
    aes_pkg::byte_t m6;
    aes_pkg::byte_t m14;
    aes_pkg::byte_t m30;
    aes_pkg::byte_t m62;
    aes_pkg::byte_t m126;
    aes_pkg::byte_t inv;

    assign p2   = gf_mul(in_byte, in_byte);
    assign p4   = gf_mul(p2, p2);
    assign p8   = gf_mul(p4, p4);
    assign p16  = gf_mul(p8, p8);
    assign p32  = gf_mul(p16, p16);
    assign p64  = gf_mul(p32, p32);
    assign p128 = gf_mul(p64, p64);

    // 254 = 2+4+8+16+32+64+128
    assign m6   = gf_mul(p2, p4);
    assign m14  = gf_mul(m6, p8);
    assign m30  = gf_mul(m14, p16);
    assign m62  = gf_mul(m30, p32);
    assign m126 = gf_mul(m62, p64);
    // x^254 is x^-1, and 0 stays 0
    assign inv  = gf_mul(m126, p128);

    // affine map: b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
    assign out_byte = inv
                    ^ {inv[6:0], inv[7]}
                    ^ {inv[5:0], inv[7:6]}
                    ^ {inv[4:0], inv[7:5]}
                    ^ {inv[3:0], inv[7:4]}
                    ^ 8'h63;

endmodule

`default_nettype wire

// File: logic/aes_load_port.sv
// aes load port, four-phase write slave that fills key and data and issues start
`default_nettype none
`timescale 1ns/1ps

module aes_load_port (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_req,
    input  aes_pkg::addr_t  in_addr,
    input  aes_pkg::word_t  in_data,
    output logic            in_ack,
    input  logic            busy,
    output aes_pkg::block_t key_block,
    output aes_pkg::block_t data_block,
    output logic            start
);

    typedef enum logic {ACK_LOW, ACK_HIGH} ack_state_t;

    ack_state_t ack_st;
    logic       capture;
    logic       is_key;
    logic       is_data;
    logic       is_ctrl;

    // rising side of the handshake, req seen while ack still low
    assign capture = (ack_st == ACK_LOW) && in_req;

    // decode, key and data blocks are 4-word aligned
    assign is_key  = (in_addr & ~aes_pkg::addr_t'(3)) == aes_pkg::ADDR_KEY0;
    assign is_data = (in_addr & ~aes_pkg::addr_t'(3)) == aes_pkg::ADDR_DATA0;
    assign is_ctrl = in_addr == aes_pkg::ADDR_CTRL;

    assign in_ack = ack_st == ACK_HIGH;

    // ack fsm plus the start pulse
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ack_st <= ACK_LOW;
            start  <= 1'b0;
        end
        else
        begin
            // one cycle pulse, only when the core is idle
            start <= capture && is_ctrl && in_data[0] && !busy;
            case (ack_st)
                ACK_LOW:
                    if (in_req)
                        ack_st <= ACK_HIGH;
                ACK_HIGH:
                    if (!in_req)
                        ack_st <= ACK_LOW;
                default:
                    ack_st <= ACK_LOW;
            endcase
        end
    end

    // word registers, writes during busy are acked and dropped
    always_ff @(posedge clk)
    begin
        if (capture && !busy)
        begin
            // word 0 lands in the top 32 bits
            if (is_key)
                key_block[(3 - in_addr[1:0]) * 32 +: 32] <= in_data;
            if (is_data)
                data_block[(3 - in_addr[1:0]) * 32 +: 32] <= in_data;
        end
    end

    // ack only follows a req seen high on the previous edge
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(in_ack) |-> $past(in_req)
    );

endmodule

`default_nettype wire

// File: logic/aes_key_schedule.sv
// aes-128 key schedule, one round key register expanded on the fly
`default_nettype none
`timescale 1ns/1ps

module aes_key_schedule (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t key_block,
    input  logic            key_load,
    input  logic            key_step,
    output aes_pkg::block_t round_key
);

    aes_pkg::block_t rk;
    aes_pkg::byte_t  rcon;
    aes_pkg::word_t  rot_word;
    wire aes_pkg::word_t sub_word;
    aes_pkg::word_t  temp;
    aes_pkg::word_t  w0;
    aes_pkg::word_t  w1;
    aes_pkg::word_t  w2;
    aes_pkg::word_t  w3;

    // rotword of the last key word
    assign rot_word = {rk[23:0], rk[31:24]};

    // subword, one s-box per byte
    for (genvar i = 0; i < 4; i++)
    begin : g_sub
        aes_sbox sbox_inst (
            .in_byte  (rot_word[i * 8 +: 8]),
            .out_byte (sub_word[i * 8 +: 8])
        );
    end

    // rcon only touches the leading byte
    assign temp = sub_word ^ {rcon, 24'h000000};

    // next round key, each word chains off the one before
    assign w0 = rk[127:96] ^ temp;
    assign w1 = rk[95:64] ^ w0;
    assign w2 = rk[63:32] ^ w1;
    assign w3 = rk[31:0] ^ w2;

    always_ff @(posedge clk)
    begin
        if (key_load)
            rk <= key_block;
        else if (key_step)
            rk <= {w0, w1, w2, w3};
    end

    // round constant, doubled in gf(2^8) per step
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rcon <= 8'h01;
        else if (key_load)
            rcon <= 8'h01;
        else if (key_step)
            rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
    end

    assign round_key = rk;

endmodule

`default_nettype wire

// File: logic/aes_round_core.sv
// aes round core, byte-serial subbytes then one-cycle shiftrows, mixcolumns, addroundkey
`default_nettype none
`timescale 1ns/1ps

module aes_round_core #(
    parameter int ROUNDS = aes_pkg::AES_ROUNDS
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  aes_pkg::block_t data_block,
    input  aes_pkg::block_t round_key,
    output logic            key_load,
    output logic            key_step,
    output logic            busy,
    input  logic            slot_full,
    output aes_pkg::block_t result,
    output logic            result_valid
);

    aes_pkg::core_state_t fsm;
    aes_pkg::core_state_t fsm_next;
    aes_pkg::block_t      state;
    aes_pkg::round_t      round;
    aes_pkg::byte_idx_t   byte_idx;
    aes_pkg::byte_t       sub_in;
    aes_pkg::byte_t       sub_out;
    aes_pkg::block_t      shifted;
    aes_pkg::block_t      round_out;
    logic                 last_round;

    function automatic aes_pkg::byte_t xtime(input aes_pkg::byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // byte i sits in row i%4, column i/4; row r rotates left by r
    function automatic aes_pkg::block_t shift_rows(input aes_pkg::block_t s);
        aes_pkg::block_t t;
        int src;
        t = '0;
        for (int i = 0; i < 16; i++)
        begin
            src = ((i / 4 + i % 4) % 4) * 4 + i % 4;
            t[(15 - i) * 8 +: 8] = s[(15 - src) * 8 +: 8];
        end
        return t;
    endfunction

    // fixed 2-3-1-1 circulant per column
    function automatic aes_pkg::block_t mix_columns(input aes_pkg::block_t s);
        aes_pkg::block_t t;
        aes_pkg::word_t  col;
        aes_pkg::byte_t  a0;
        aes_pkg::byte_t  a1;
        aes_pkg::byte_t  a2;
        aes_pkg::byte_t  a3;
        t = '0;
        for (int c = 0; c < 4; c++)
        begin
            col = s[(3 - c) * 32 +: 32];
            a0  = col[31:24];
            a1  = col[23:16];
            a2  = col[15:8];
            a3  = col[7:0];
            t[(3 - c) * 32 +: 32] = {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                                     a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                                     a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                                     xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
        end
        return t;
    endfunction

    // byte picked by the serial index
    assign sub_in = state[(15 - byte_idx) * 8 +: 8];

    aes_sbox sbox_inst (
        .in_byte  (sub_in),
        .out_byte (sub_out)
    );

    // final round has no mixcolumns
    assign last_round = round == ROUNDS;
    assign shifted    = shift_rows(state);
    assign round_out  = (last_round ? shifted : mix_columns(shifted)) ^ round_key;

    always_comb
    begin
        fsm_next = fsm;
        case (fsm)
            aes_pkg::IDLE:
                if (start)
                    fsm_next = aes_pkg::INIT_ADD;
            aes_pkg::INIT_ADD:
                fsm_next = aes_pkg::SUB_BYTES;
            aes_pkg::SUB_BYTES:
                if (byte_idx == aes_pkg::byte_idx_t'(15))
                    fsm_next = aes_pkg::MIX_ADD;
            aes_pkg::MIX_ADD:
                fsm_next = last_round ? aes_pkg::HOLD : aes_pkg::SUB_BYTES;
            aes_pkg::HOLD:
                // wait for the output slot
                if (!slot_full)
                    fsm_next = aes_pkg::IDLE;
            default:
                fsm_next = aes_pkg::IDLE;
        endcase
    end

    // fsm, round counter and byte index
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fsm      <= aes_pkg::IDLE;
            round    <= '0;
            byte_idx <= '0;
        end
        else
        begin
            fsm <= fsm_next;
            case (fsm)
                aes_pkg::IDLE:
                    round <= '0;
                aes_pkg::INIT_ADD:
                begin
                    round    <= aes_pkg::round_t'(1);
                    byte_idx <= '0;
                end
                aes_pkg::SUB_BYTES:
                    // wraps back to 0 after byte 15
                    byte_idx <= byte_idx + aes_pkg::byte_idx_t'(1);
                aes_pkg::MIX_ADD:
                    if (!last_round)
                        round <= round + aes_pkg::round_t'(1);
                default:
                    byte_idx <= '0;
            endcase
        end
    end

    // state datapath
    always_ff @(posedge clk)
    begin
        case (fsm)
            aes_pkg::IDLE:
                if (start)
                    state <= data_block;
            aes_pkg::INIT_ADD:
                state <= state ^ round_key;
            aes_pkg::SUB_BYTES:
                state[(15 - byte_idx) * 8 +: 8] <= sub_out;
            aes_pkg::MIX_ADD:
                state <= round_out;
            default:
                state <= state;
        endcase
    end

    // key schedule loads on start, steps after each key use except the last
    assign key_load     = (fsm == aes_pkg::IDLE) && start;
    assign key_step     = (fsm == aes_pkg::INIT_ADD) || ((fsm == aes_pkg::MIX_ADD) && !last_round);
    assign busy         = fsm != aes_pkg::IDLE;
    assign result       = state;
    assign result_valid = (fsm == aes_pkg::HOLD) && !slot_full;

    a_round_bound: assert property (
        @(posedge clk) disable iff (!resetn)
        round <= ROUNDS
    );

    // result port must take the block and mark its slot full
    a_result_slot: assert property (
        @(posedge clk) disable iff (!resetn)
        result_valid |-> !slot_full ##1 slot_full
    );

endmodule

`default_nettype wire

// File: logic/aes_result_port.sv
// aes result port, one ciphertext slot offered over a four-phase handshake
`default_nettype none
`timescale 1ns/1ps

module aes_result_port (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t result,
    input  logic            result_valid,
    output logic            slot_full,
    output logic            out_req,
    output aes_pkg::block_t out_data,
    input  logic            out_ack
);

    typedef enum logic [1:0] {SLOT_RELEASED, SLOT_OFFERING, SLOT_ACKED} slot_state_t;

    slot_state_t slot_st;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            slot_st <= SLOT_RELEASED;
        else
        begin
            case (slot_st)
                SLOT_RELEASED:
                    if (result_valid)
                        slot_st <= SLOT_OFFERING;
                SLOT_OFFERING:
                    if (out_ack)
                        slot_st <= SLOT_ACKED;
                SLOT_ACKED:
                    // slot frees on the falling ack
                    if (!out_ack)
                        slot_st <= SLOT_RELEASED;
                default:
                    slot_st <= SLOT_RELEASED;
            endcase
        end
    end

    // capture once per result
    always_ff @(posedge clk)
    begin
        if ((slot_st == SLOT_RELEASED) && result_valid)
            out_data <= result;
    end

    assign out_req   = slot_st == SLOT_OFFERING;
    assign slot_full = slot_st != SLOT_RELEASED;

    a_data_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        out_req ##1 out_req |-> $stable(out_data)
    );

endmodule

`default_nettype wire

// File: logic/aes_enc_top.sv
// aes-128 encryption engine top, load port to round core to result port
`default_nettype none
`timescale 1ns/1ps

module aes_enc_top (
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_req,
    input  aes_pkg::addr_t  in_addr,
    input  aes_pkg::word_t  in_data,
    output logic            in_ack,
    output logic            out_req,
    output aes_pkg::block_t out_data,
    input  logic            out_ack,
    output logic            busy
);

    // load port to core
    aes_pkg::block_t key_block;
    aes_pkg::block_t data_block;
    logic            start;
    // core to key schedule
    logic            key_load;
    logic            key_step;
    aes_pkg::block_t round_key;
    // core to result port
    aes_pkg::block_t result;
    logic            result_valid;
    logic            slot_full;

    aes_load_port aes_load_port_inst (
        .clk        (clk),
        .resetn     (resetn),
        .in_req     (in_req),
        .in_addr    (in_addr),
        .in_data    (in_data),
        .in_ack     (in_ack),
        .busy       (busy),
        .key_block  (key_block),
        .data_block (data_block),
        .start      (start)
    );

    aes_round_core #(
        .ROUNDS (aes_pkg::AES_ROUNDS)
    ) aes_round_core_inst (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .data_block   (data_block),
        .round_key    (round_key),
        .key_load     (key_load),
        .key_step     (key_step),
        .busy         (busy),
        .slot_full    (slot_full),
        .result       (result),
        .result_valid (result_valid)
    );

    aes_key_schedule aes_key_schedule_inst (
        .clk       (clk),
        .resetn    (resetn),
        .key_block (key_block),
        .key_load  (key_load),
        .key_step  (key_step),
        .round_key (round_key)
    );

    aes_result_port aes_result_port_inst (
        .clk          (clk),
        .resetn       (resetn),
        .result       (result),
        .result_valid (result_valid),
        .slot_full    (slot_full),
        .out_req      (out_req),
        .out_data     (out_data),
        .out_ack      (out_ack)
    );

endmodule

`default_nettype wire

// File: verif/aes_ref_model.svh
// aes-128 behavioral model for the testbench, s-box found by brute-force inversion
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// carry-less multiply, reduced by 0x11b
function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ x;
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// search every candidate for the inverse, then the affine map bit by bit
function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [7:0] inv;
    logic [7:0] s;
    inv = 8'h00;
    for (int y = 1; y < 256; y++)
    begin
        if (b != 8'h00 && gf_mult(b, 8'(y)) == 8'h01)
            inv = 8'(y);
    end
    for (int i = 0; i < 8; i++)
        s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
             ^ inv[(i + 7) % 8];
    return s ^ 8'h63;
endfunction

// full encryption on byte arrays, byte 0 is the msb of the block
function automatic logic [127:0] aes128_encrypt(input logic [127:0] key, input logic [127:0] pt);
    logic [7:0] s [16];
    logic [7:0] t [16];
    logic [7:0] k [16];
    logic [7:0] g [4];
    logic [7:0] rc;
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    logic [127:0] ct;
    for (int i = 0; i < 16; i++)
    begin
        k[i] = key[(15 - i) * 8 +: 8];
        s[i] = pt[(15 - i) * 8 +: 8] ^ k[i];
    end
    rc = 8'h01;
    for (int r = 1; r <= 10; r++)
    begin
        // next round key from rotated, substituted last word
        g[0] = sub_byte(k[13]) ^ rc;
        g[1] = sub_byte(k[14]);
        g[2] = sub_byte(k[15]);
        g[3] = sub_byte(k[12]);
        for (int i = 0; i < 16; i++)
        begin
            if (i < 4)
                k[i] = k[i] ^ g[i];
            else
                k[i] = k[i] ^ k[i - 4];
        end
        rc = gf_mult(rc, 8'h02);
        // subbytes with shiftrows folded into the source index
        for (int i = 0; i < 16; i++)
            t[i] = sub_byte(s[4 * (((i / 4) + (i % 4)) % 4) + i % 4]);
        for (int c = 0; c < 4; c++)
        begin
            a0 = t[4 * c];
            a1 = t[4 * c + 1];
            a2 = t[4 * c + 2];
            a3 = t[4 * c + 3];
            if (r < 10)
            begin
                s[4 * c]     = gf_mult(a0, 8'h02) ^ gf_mult(a1, 8'h03) ^ a2 ^ a3;
                s[4 * c + 1] = a0 ^ gf_mult(a1, 8'h02) ^ gf_mult(a2, 8'h03) ^ a3;
                s[4 * c + 2] = a0 ^ a1 ^ gf_mult(a2, 8'h02) ^ gf_mult(a3, 8'h03);
                s[4 * c + 3] = gf_mult(a0, 8'h03) ^ a1 ^ a2 ^ gf_mult(a3, 8'h02);
            end
            else
            begin
                s[4 * c]     = a0;
                s[4 * c + 1] = a1;
                s[4 * c + 2] = a2;
                s[4 * c + 3] = a3;
            end
        end
        for (int i = 0; i < 16; i++)
            s[i] = s[i] ^ k[i];
    end
    for (int i = 0; i < 16; i++)
        ct[(15 - i) * 8 +: 8] = s[i];
    return ct;
endfunction

`endif

// File: verif/aes_enc_tb.sv
// aes-128 engine testbench, fixed and random blocks checked against a behavioral model
`default_nettype none
`timescale 1ns/1ps

module aes_enc_tb;

    `include "aes_ref_model.svh"

    // fips-197 appendix c.1
    localparam logic [127:0] FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    localparam int RANDOM_BLOCKS  = 20;
    localparam int BACKOFF_BLOCKS = 8;
    // every block of the run, the aborted one included
    localparam int NUM_BLOCKS     = 1 + RANDOM_BLOCKS + (BACKOFF_BLOCKS + 1) + 3 + 2;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 200 + 2000;
    // 172 core cycles plus handshake slack
    localparam int MAX_LATENCY    = 180;

    logic            clk;
    logic            resetn;
    logic            in_req;
    aes_pkg::addr_t  in_addr;
    aes_pkg::word_t  in_data;
    logic            in_ack;
    logic            out_req;
    aes_pkg::block_t out_data;
    logic            out_ack;
    logic            busy;

    int seed;
    int cycle;
    int checks;
    int errors;

    aes_enc_top aes_enc_top_inst (
        .clk      (clk),
        .resetn   (resetn),
        .in_req   (in_req),
        .in_addr  (in_addr),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack),
        .busy     (busy)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // cycle count and watchdog
    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle);
            $display("test failed");
            $finish;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        resetn = 1'b0;
        repeat (4) @(negedge clk);
        resetn = 1'b1;
    endtask

    // one four-phase write, returns once ack is low again
    task automatic write_word(input aes_pkg::addr_t addr, input aes_pkg::word_t data);
        @(negedge clk);
        in_addr = addr;
        in_data = data;
        in_req  = 1'b1;
        while (!in_ack)
            @(negedge clk);
        in_req = 1'b0;
        while (in_ack)
            @(negedge clk);
    endtask

    // key words, data words, then the start bit
    task automatic load_block(input aes_pkg::block_t key, input aes_pkg::block_t pt);
        for (int i = 0; i < 4; i++)
            write_word(aes_pkg::ADDR_KEY0 + aes_pkg::addr_t'(i), key[(3 - i) * 32 +: 32]);
        for (int i = 0; i < 4; i++)
            write_word(aes_pkg::ADDR_DATA0 + aes_pkg::addr_t'(i), pt[(3 - i) * 32 +: 32]);
        write_word(aes_pkg::ADDR_CTRL, 32'h0000_0001);
    endtask

    // consumer side, holds off ack for delay cycles while watching out_data
    task automatic receive_block(input int delay, output aes_pkg::block_t data, output int rise);
        while (!out_req)
            @(negedge clk);
        rise = cycle;
        data = out_data;
        checks++;
        repeat (delay)
        begin
            @(negedge clk);
            assert (out_req && out_data === data)
            else
            begin
                $display("[FAIL] %0d ns: out_data %h changed while offered", $time, out_data);
                errors++;
            end
        end
        out_ack = 1'b1;
        while (out_req)
            @(negedge clk);
        out_ack = 1'b0;
    endtask

    task automatic check_block(input string what, input aes_pkg::block_t got,
                               input aes_pkg::block_t exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // no result may be offered for n cycles
    task automatic expect_quiet(input int n);
        checks++;
        repeat (n)
        begin
            @(negedge clk);
            assert (!out_req)
            else
            begin
                $display("unexpected result offered at %0d ns", $time);
                errors++;
            end
        end
    endtask

    task automatic random_block(output aes_pkg::block_t b);
        b = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // full encryption, latency bound and value check
    task automatic run_block(input aes_pkg::block_t key, input aes_pkg::block_t pt,
                             input int delay, input string what);
        aes_pkg::block_t got;
        int start_cycle;
        int rise;
        load_block(key, pt);
        start_cycle = cycle;
        receive_block(delay, got, rise);
        checks++;
        assert (rise - start_cycle <= MAX_LATENCY)
        else
        begin
            $display("result too late: out_req rose %0d cycles after the start write",
                     rise - start_cycle);
            errors++;
        end
        check_block(what, got, aes128_encrypt(key, pt));
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("[test %0d] %s: %0d errors", num, name, errors - errs_before);
    endtask

    initial
    begin
        aes_pkg::block_t key;
        aes_pkg::block_t pt;
        aes_pkg::block_t key2;
        aes_pkg::block_t pt2;
        aes_pkg::block_t got;
        int rise;
        int delay;
        int errs_before;
        clk     = 1'b0;
        resetn  = 1'b0;
        in_req  = 1'b0;
        in_addr = '0;
        in_data = '0;
        out_ack = 1'b0;
        seed    = 32'h661e_cafc;
        cycle   = 0;
        checks  = 0;
        errors  = 0;
        apply_reset();

        // 1: published vector, model and dut
        errs_before = errors;
        check_block("model on fips-197 vector", aes128_encrypt(FIPS_KEY, FIPS_PT), FIPS_CT);
        load_block(FIPS_KEY, FIPS_PT);
        receive_block(0, got, rise);
        check_block("dut on fips-197 vector", got, FIPS_CT);
        report_test(1, "fips-197 vector", errs_before);

        // 2: random blocks, immediate ack
        errs_before = errors;
        for (int n = 0; n < RANDOM_BLOCKS; n++)
        begin
            random_block(key);
            random_block(pt);
            run_block(key, pt, 0, "random block");
        end
        report_test(2, "random blocks", errs_before);

        // 3 consumer stalls while the next block finishes and waits in hold
        errs_before = errors;
        random_block(key);
        random_block(pt);
        load_block(key, pt);
        for (int n = 0; n < BACKOFF_BLOCKS; n++)
        begin
            random_block(key2);
            random_block(pt2);
            delay = int'($unsigned($random(seed)) % 51);
            while (!out_req)
                @(negedge clk);
            // next block starts behind the unread result
            load_block(key2, pt2);
            // full run of the next block plus 0 to 50 more cycles
            receive_block(MAX_LATENCY + delay, got, rise);
            check_block("back-pressure block", got, aes128_encrypt(key, pt));
            key = key2;
            pt  = pt2;
        end
        receive_block(0, got, rise);
        check_block("block held in hold", got, aes128_encrypt(key, pt));
        report_test(3, "back-pressure", errs_before);

        // 4: new inputs and a second start while busy are dropped
        errs_before = errors;
        random_block(key);
        random_block(pt);
        random_block(key2);
        random_block(pt2);
        load_block(key, pt);
        checks++;
        assert (busy)
        else
        begin
            $display("core not busy right after start");
            errors++;
        end
        load_block(key2, pt2);
        receive_block(0, got, rise);
        check_block("result with busy writes", got, aes128_encrypt(key, pt));
        expect_quiet(200);
        // bare start still sees the first key and data
        write_word(aes_pkg::ADDR_CTRL, 32'h0000_0001);
        receive_block(0, got, rise);
        check_block("restart after dropped writes", got, aes128_encrypt(key, pt));
        run_block(key2, pt2, 0, "clean start after busy");
        report_test(4, "writes during busy", errs_before);

        // 5: reset in the middle of a run
        errs_before = errors;
        random_block(key);
        random_block(pt);
        load_block(key, pt);
        repeat (80) @(negedge clk);
        apply_reset();
        checks++;
        assert (!in_ack && !out_req && !busy)
        else
        begin
            $display("outputs not cleared by reset: in_ack %b out_req %b busy %b",
                     in_ack, out_req, busy);
            errors++;
        end
        expect_quiet(200);
        random_block(key);
        random_block(pt);
        run_block(key, pt, 0, "block after reset");
        report_test(5, "reset mid-encryption", errs_before);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: aes_enc_top.f
+incdir+verif
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/aes_load_port.sv
logic/aes_key_schedule.sv
logic/aes_round_core.sv
logic/aes_result_port.sv
logic/aes_enc_top.sv
verif/aes_enc_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= aes_enc_tb
RTL_TOP    ?= aes_enc_top
FILELIST   ?= aes_enc_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the simulation output
run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
